//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tcdm_tb -f build.f
	./obj_dir/Vtcdm_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tcdm_tb.sv
// Self-checking testbench for the TCDM cluster; build with build.f and run tcdm_tb as top
`include "tcdm_cfg.svh"

module tcdm_tb import tcdm_pkg::*; ();

  localparam int num_ini   = `TCDM_NUM_INI;
  localparam int num_bank  = `TCDM_NUM_BANK;
  localparam int max_out   = `TCDM_NUM_OUTSTANDING;
  localparam int num_bytes = `TCDM_DATA_W / 8;

  logic                clk = 1'b0;
  logic                rst_n;
  logic  [num_ini-1:0] req;
  logic  [num_ini-1:0] gnt;
  addr_t [num_ini-1:0] addr;
  logic  [num_ini-1:0] wen;
  data_t [num_ini-1:0] wdata;
  be_t   [num_ini-1:0] be;
  logic  [num_ini-1:0] vld;
  logic  [num_ini-1:0] rdy;
  data_t [num_ini-1:0] rdata;

  logic [7:0]          ref_mem [256];                 // Byte-addressed reference memory
  data_t               exp_q [num_ini*num_bank][$];   // Expected responses per initiator and bank
  int                  pending [num_bank];            // Grants still waiting for a response
  int                  passed [num_ini];              // Grants to others while waiting
  int                  grants;
  int                  responses;
  logic  [num_ini-1:0] gnt_seen;
  logic  [num_ini-1:0] vld_seen;
  data_t [num_ini-1:0] last_rdata;
  logic [31:0]         rng_state = 32'hf7a4_b637;

  always #4 clk = ~clk;

  tcdm_cluster_top dut (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .req_i   (req),
    .gnt_o   (gnt),
    .addr_i  (addr),
    .wen_i   (wen),
    .wdata_i (wdata),
    .be_i    (be),
    .vld_o   (vld),
    .rdy_i   (rdy),
    .rdata_o (rdata)
  );

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string msg);
    $display("FAIL at %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_timeout(string what, int limit);
    $display("Timeout: %s did not finish within %0d cycles", what, limit);
    abort_run();
  endtask

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Bank index sits just above the byte offset
  function automatic bank_idx_t bank_of(addr_t a);
    return bank_idx_t'(a >> 2);
  endfunction

  function automatic data_t fill_word(addr_t a);
    return data_t'({a ^ 16'hc3a5, a});  // Unique per address
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t s);
    data_t m;
    m = old_w;
    for (int j = 0; j < num_bytes; j++) begin
      if (s[j]) m[8*j +: 8] = new_w[8*j +: 8];
    end
    return m;
  endfunction

  function automatic data_t ref_word(addr_t a);
    data_t w;
    for (int j = 0; j < num_bytes; j++) begin
      w[8*j +: 8] = ref_mem[{a[7:2], 2'(j)}];
    end
    return w;
  endfunction

  task automatic set_request(int i, addr_t a, logic w, data_t d, be_t s);
    req[i]   = 1'b1;
    addr[i]  = a;
    wen[i]   = w;
    wdata[i] = d;
    be[i]    = s;
  endtask

  // Runs mid low phase, values match what the next rising edge samples
  task automatic sample_cycle();
    int  b;
    int  src;
    bit  hit;
    gnt_seen = gnt;
    vld_seen = vld;
    for (int i = 0; i < num_ini; i++) begin  // Responses first, they belong to older grants
      if (vld[i]) begin
        hit = 1'b0;
        src = 0;
        for (int k = 0; k < num_bank; k++) begin
          if (!hit && exp_q[i*num_bank+k].size() > 0 && exp_q[i*num_bank+k][0] == rdata[i]) begin
            hit = 1'b1;
            src = k;
          end
        end
        assert (hit) else report_mismatch($sformatf("initiator %0d got rdata %h", i, rdata[i]));
        if (rdy[i]) begin
          void'(exp_q[i*num_bank+src].pop_front());
          pending[src]--;
          responses++;
          last_rdata[i] = rdata[i];
        end
      end
    end
    for (int i = 0; i < num_ini; i++) begin
      if (gnt[i]) begin
        b = bank_of(addr[i]);
        if (wen[i]) begin
          for (int j = 0; j < num_bytes; j++) begin
            if (be[i][j]) ref_mem[{addr[i][7:2], 2'(j)}] = wdata[i][8*j +: 8];
          end
          exp_q[i*num_bank+b].push_back('0);  // Write answers zero
        end else begin
          exp_q[i*num_bank+b].push_back(ref_word(addr[i]));
        end
        pending[b]++;
        grants++;
        assert (pending[b] <= max_out)
          else report_mismatch($sformatf("bank %0d has %0d open grants", b, pending[b]));
      end
    end
    // Round robin, nobody waits past the other initiators
    for (int i = 0; i < num_ini; i++) begin
      if (!req[i] || gnt[i]) begin
        passed[i] = 0;
      end else begin
        for (int k = 0; k < num_ini; k++) begin
          if (k != i && gnt[k] && bank_of(addr[k]) == bank_of(addr[i])) passed[i]++;
        end
      end
      assert (passed[i] < num_ini)
        else report_mismatch($sformatf("initiator %0d passed over %0d times", i, passed[i]));
    end
  endtask

  task automatic run_cycle();
    #2;
    sample_cycle();
    @(negedge clk);
    req = req & ~gnt_seen;  // Granted requests retire
  endtask

  task automatic wait_grant(int i, string what);
    int cnt;
    cnt = 0;
    run_cycle();
    while (!gnt_seen[i]) begin
      cnt++;
      if (cnt > 50) report_timeout(what, 50);
      run_cycle();
    end
  endtask

  task automatic wait_drain(string what);
    int cnt;
    cnt = 0;
    while (req != '0 || grants != responses) begin
      run_cycle();
      cnt++;
      if (cnt > 400) report_timeout(what, 400);
    end
  endtask

  // Grants only for live requests
  a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) (gnt & ~req) == '0)
    else report_mismatch("gnt_o without req_i");

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (gnt == '0 && vld == '0))
    else report_mismatch("gnt_o or vld_o active in reset");

  for (genvar i = 0; i < num_ini; i++) begin : gen_hold
    a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
      $past(vld[i] && !rdy[i]) |-> (vld[i] && rdata[i] == $past(rdata[i])))
      else report_mismatch($sformatf("initiator %0d rdata moved while stalled", i));
  end

  initial begin
    int          loops;
    int          queued;
    int          leftover;
    int          next_row [num_ini];
    logic [31:0] r;
    addr_t       a;
    rst_n = 1'b0;
    req = '0;
    addr = '0;
    wen = '0;
    wdata = '0;
    be = '0;
    rdy = '0;
    grants = 0;
    responses = 0;
    gnt_seen = '0;
    vld_seen = '0;
    last_rdata = '0;
    loops = 0;
    queued = 0;
    for (int k = 0; k < num_bank; k++) pending[k] = 0;
    for (int i = 0; i < num_ini; i++) begin
      passed[i] = 0;
      next_row[i] = 0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (8) begin  // Idle, nothing may move
      run_cycle();
      assert (gnt_seen == '0 && vld_seen == '0) else report_mismatch("activity while idle");
    end

    // Preload, initiator i owns bank i
    rdy = '1;
    while (req != '0 || queued < 16 * num_ini) begin
      for (int i = 0; i < num_ini; i++) begin
        if (!req[i] && next_row[i] < 16) begin
          a = addr_t'((next_row[i] * num_bank + i) * 4);
          set_request(i, a, 1'b1, fill_word(a), '1);
          next_row[i]++;
          queued++;
        end
      end
      run_cycle();
      loops++;
      if (loops > 300) report_timeout("memory preload", 300);
    end
    wait_drain("preload responses");

    // Partial write then read back
    set_request(0, 16'h0024, 1'b1, 32'h1122_3344, 4'b0110);
    wait_grant(0, "partial write grant");
    set_request(0, 16'h0024, 1'b0, '0, '0);
    wait_grant(0, "read-back grant");
    wait_drain("read-back response");
    assert (last_rdata[0] == merge_bytes(fill_word(16'h0024), 32'h1122_3344, 4'b0110))
      else report_mismatch($sformatf("merged read-back %h", last_rdata[0]));

    for (int n = 0; n < 40; n++) begin  // Everyone on bank 1
      for (int i = 0; i < num_ini; i++) begin
        r = rand_word();
        if (!req[i]) set_request(i, addr_t'({r[3:0], 2'd1, 2'b00}), 1'b0, '0, '0);
      end
      run_cycle();
    end
    wait_drain("shared bank traffic");

    rdy = '0;  // Stall responses, credits must run out on bank 2
    for (int n = 0; n < 24; n++) begin
      for (int i = 0; i < num_ini; i++) begin
        r = rand_word();
        if (!req[i]) set_request(i, addr_t'({r[3:0], 2'd2, 2'b00}), 1'b0, '0, '0);
      end
      run_cycle();
    end
    assert (pending[2] == max_out)
      else report_mismatch($sformatf("bank 2 stopped at %0d open grants", pending[2]));
    rdy = '1;
    wait_drain("responses after back-pressure");

    for (int n = 0; n < 800; n++) begin  // Random traffic, rdy high about 3 in 4
      r = rand_word();
      rdy = r[num_ini-1:0] | r[2*num_ini-1:num_ini];
      for (int i = 0; i < num_ini; i++) begin
        r = rand_word();
        // Writes stay on bank i so each zero response has one source
        a = addr_t'({r[13:10], r[1] ? 2'(i) : r[9:8], 2'b00});
        if (!req[i] && r[0]) set_request(i, a, r[1], rand_word(), be_t'(r[7:4]));
      end
      run_cycle();
    end
    rdy = '1;
    wait_drain("random traffic");

    leftover = 0;
    for (int q = 0; q < num_ini * num_bank; q++) leftover += exp_q[q].size();
    if (leftover == 0 && grants == responses && grants > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_mismatch($sformatf("%0d responses missing, %0d grants, %0d responses",
                                leftover, grants, responses));
    end
  end

endmodule

//--- build.f
+incdir+rtl
rtl/tcdm_pkg.sv
rtl/tcdm_if.sv
rtl/tcdm_req_xbar.sv
rtl/tcdm_resp_xbar.sv
rtl/tcdm_target_queue.sv
rtl/tcdm_interconnect.sv
rtl/tcdm_bank.sv
rtl/tcdm_cluster_top.sv
bench/tcdm_tb.sv

//--- rtl/tcdm_bank.sv
// Single-port word memory bank with byte strobes and a fixed-latency response pipeline
`include "tcdm_cfg.svh"

module tcdm_bank import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  tcdm_req_if.slv   req,   // Always accepted
  tcdm_resp_if.mst  resp
);

  localparam int unsigned num_rows  = 2 ** `TCDM_ROW_W;
  localparam int unsigned lat       = `TCDM_BANK_LAT;
  localparam int unsigned num_bytes = `TCDM_DATA_W / 8;

  data_t mem_q [num_rows];

  logic     [lat-1:0] vld_q;    // Response pipeline
  ini_idx_t [lat-1:0] ini_q;
  data_t    [lat-1:0] rdata_q;

  // Byte-strobed write
  always_ff @(posedge clk_i) begin
    if (req.req && req.bank_req.wen) begin
      for (int j = 0; j < num_bytes; j++) begin
        if (req.bank_req.be[j]) begin
          mem_q[req.bank_req.row][8*j +: 8] <= req.bank_req.wdata[8*j +: 8];
        end
      end
    end
  end

  // Payload stages, first one samples the array
  always_ff @(posedge clk_i) begin
    ini_q[0]   <= req.ini;
    rdata_q[0] <= req.bank_req.wen ? '0 : mem_q[req.bank_req.row];  // Writes answer zero
    for (int k = 1; k < lat; k++) begin
      ini_q[k]   <= ini_q[k-1];
      rdata_q[k] <= rdata_q[k-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= req.req;
      for (int k = 1; k < lat; k++) begin
        vld_q[k] <= vld_q[k-1];
      end
    end
  end

  // Last stage, lat cycles after the accepting edge
  assign resp.vld   = vld_q[lat-1];
  assign resp.ini   = ini_q[lat-1];
  assign resp.rdata = rdata_q[lat-1];

endmodule

//--- rtl/tcdm_cfg.svh
// Sizing macros for the TCDM cluster; include in the package and in any RTL file that sizes logic
`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// Initiators, one word each
`define TCDM_NUM_INI 4

// Word-interleaved banks
`define TCDM_NUM_BANK 4

// Byte address and data word
`define TCDM_ADDR_W 16
`define TCDM_DATA_W 32

// Word rows per bank, as address bits
`define TCDM_ROW_W 6

// Accepting edge to bank vld, in cycles
`define TCDM_BANK_LAT 2

// Response queue depth, also the credit limit per bank
`define TCDM_NUM_OUTSTANDING 4

`endif

//--- rtl/tcdm_cluster_top.sv
// Cluster top level: plain initiator ports into the interconnect and its four memory banks
`include "tcdm_cfg.svh"

module tcdm_cluster_top import tcdm_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic  [`TCDM_NUM_INI-1:0]      req_i,
  output logic  [`TCDM_NUM_INI-1:0]      gnt_o,
  input  addr_t [`TCDM_NUM_INI-1:0]      addr_i,
  input  logic  [`TCDM_NUM_INI-1:0]      wen_i,
  input  data_t [`TCDM_NUM_INI-1:0]      wdata_i,
  input  be_t   [`TCDM_NUM_INI-1:0]      be_i,
  output logic  [`TCDM_NUM_INI-1:0]      vld_o,
  input  logic  [`TCDM_NUM_INI-1:0]      rdy_i,
  output data_t [`TCDM_NUM_INI-1:0]      rdata_o
);

  tcdm_req_if  req_bus  [`TCDM_NUM_BANK] ();  // One pair per bank
  tcdm_resp_if resp_bus [`TCDM_NUM_BANK] ();

  tcdm_interconnect u_interconnect (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .gnt_o     (gnt_o),
    .addr_i    (addr_i),
    .wen_i     (wen_i),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .vld_o     (vld_o),
    .rdy_i     (rdy_i),
    .rdata_o   (rdata_o),
    .bank_req  (req_bus),
    .bank_resp (resp_bus)
  );

  for (genvar b = 0; b < `TCDM_NUM_BANK; b++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req    (req_bus[b]),
      .resp   (resp_bus[b])
    );
  end

endmodule

//--- rtl/tcdm_if.sv
// Bank-side request and response bundles between the interconnect and each memory bank

// Request towards a bank, accepted in every cycle with req high
interface tcdm_req_if import tcdm_pkg::*; ();

  logic      req;       // Request strobe, no grant comes back
  ini_idx_t  ini;       // Requesting initiator
  bank_req_t bank_req;  // Packed request fields

  modport mst (
    output req, ini, bank_req
  );

  modport slv (
    input  req, ini, bank_req
  );

endinterface

// Response from a bank, one-cycle vld pulse without back-pressure
interface tcdm_resp_if import tcdm_pkg::*; ();

  logic     vld;    // Response strobe
  ini_idx_t ini;    // Destination initiator
  data_t    rdata;  // Read data, zero for writes

  modport mst (
    output vld, ini, rdata
  );

  modport slv (
    input  vld, ini, rdata
  );

endinterface

//--- rtl/tcdm_interconnect.sv
// Variable-latency full crossbar between the initiators and the bank request/response bundles
`include "tcdm_cfg.svh"

module tcdm_interconnect import tcdm_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic  [`TCDM_NUM_INI-1:0]      req_i,
  output logic  [`TCDM_NUM_INI-1:0]      gnt_o,
  input  addr_t [`TCDM_NUM_INI-1:0]      addr_i,
  input  logic  [`TCDM_NUM_INI-1:0]      wen_i,
  input  data_t [`TCDM_NUM_INI-1:0]      wdata_i,
  input  be_t   [`TCDM_NUM_INI-1:0]      be_i,
  output logic  [`TCDM_NUM_INI-1:0]      vld_o,
  input  logic  [`TCDM_NUM_INI-1:0]      rdy_i,
  output data_t [`TCDM_NUM_INI-1:0]      rdata_o,
  tcdm_req_if.mst                        bank_req  [`TCDM_NUM_BANK],
  tcdm_resp_if.slv                       bank_resp [`TCDM_NUM_BANK]
);

  logic      [`TCDM_NUM_BANK-1:0] xbar_vld;   // Granted request per bank
  bank_req_t [`TCDM_NUM_BANK-1:0] xbar_req;
  ini_idx_t  [`TCDM_NUM_BANK-1:0] xbar_ini;
  logic      [`TCDM_NUM_BANK-1:0] bank_free;  // Credit state
  logic      [`TCDM_NUM_BANK-1:0] q_vld;      // Queue heads
  ini_idx_t  [`TCDM_NUM_BANK-1:0] q_ini;
  data_t     [`TCDM_NUM_BANK-1:0] q_rdata;
  logic      [`TCDM_NUM_BANK-1:0] q_pop;

  tcdm_req_xbar u_req_xbar (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .wen_i       (wen_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .bank_free_i (bank_free),
    .gnt_o       (gnt_o),
    .bank_req_o  (xbar_req),
    .bank_ini_o  (xbar_ini),
    .bank_vld_o  (xbar_vld)
  );

  for (genvar b = 0; b < `TCDM_NUM_BANK; b++) begin : gen_bank
    assign bank_req[b].req      = xbar_vld[b];  // Bank takes it in the same cycle
    assign bank_req[b].ini      = xbar_ini[b];
    assign bank_req[b].bank_req = xbar_req[b];

    tcdm_target_queue u_queue (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .accept_i     (xbar_vld[b]),
      .resp         (bank_resp[b]),
      .pop_i        (q_pop[b]),
      .free_o       (bank_free[b]),
      .head_vld_o   (q_vld[b]),
      .head_ini_o   (q_ini[b]),
      .head_rdata_o (q_rdata[b])
    );
  end

  tcdm_resp_xbar u_resp_xbar (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .q_vld_i   (q_vld),
    .q_ini_i   (q_ini),
    .q_rdata_i (q_rdata),
    .q_pop_o   (q_pop),
    .vld_o     (vld_o),
    .rdy_i     (rdy_i),
    .rdata_o   (rdata_o)
  );

endmodule

//--- rtl/tcdm_pkg.sv
// Shared types of the TCDM cluster; modules pull them in with a wildcard import
`include "tcdm_cfg.svh"

package tcdm_pkg;

  typedef logic [`TCDM_ADDR_W-1:0]   addr_t;   // Initiator byte address
  typedef logic [`TCDM_DATA_W-1:0]   data_t;   // Data word
  typedef logic [`TCDM_DATA_W/8-1:0] be_t;     // One strobe per byte

  // Bank index sits right above the byte offset
  typedef logic [$clog2(`TCDM_NUM_BANK)-1:0] bank_idx_t;

  // Word row inside a bank, above the bank index
  typedef logic [`TCDM_ROW_W-1:0] row_t;

  // Tags every request and response with its source
  typedef logic [$clog2(`TCDM_NUM_INI)-1:0] ini_idx_t;

  // Request as seen by a bank
  typedef struct packed {
    logic  wen;    // High for a write
    be_t   be;     // Byte strobes
    row_t  row;    // Word row
    data_t wdata;  // Write data
  } bank_req_t;

endpackage

//--- rtl/tcdm_req_xbar.sv
// Request crossbar: decodes the bank of each initiator request and arbitrates per bank
`include "tcdm_cfg.svh"

module tcdm_req_xbar import tcdm_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic      [`TCDM_NUM_INI-1:0]        req_i,
  input  addr_t     [`TCDM_NUM_INI-1:0]        addr_i,
  input  logic      [`TCDM_NUM_INI-1:0]        wen_i,
  input  data_t     [`TCDM_NUM_INI-1:0]        wdata_i,
  input  be_t       [`TCDM_NUM_INI-1:0]        be_i,
  input  logic      [`TCDM_NUM_BANK-1:0]       bank_free_i,  // Credits left per bank
  output logic      [`TCDM_NUM_INI-1:0]        gnt_o,
  output bank_req_t [`TCDM_NUM_BANK-1:0]       bank_req_o,
  output ini_idx_t  [`TCDM_NUM_BANK-1:0]       bank_ini_o,
  output logic      [`TCDM_NUM_BANK-1:0]       bank_vld_o    // Granted request per bank
);

  localparam int unsigned num_ini    = `TCDM_NUM_INI;
  localparam int unsigned num_bank   = `TCDM_NUM_BANK;
  localparam int unsigned byte_off_w = $clog2(`TCDM_DATA_W/8);
  localparam int unsigned bank_w     = $clog2(`TCDM_NUM_BANK);

  bank_idx_t [num_ini-1:0] bank_sel;  // Decoded target bank
  bank_req_t [num_ini-1:0] ini_req;   // Packed request per initiator

  for (genvar i = 0; i < num_ini; i++) begin : gen_ini
    assign bank_sel[i] = addr_i[i][byte_off_w +: bank_w];  // Word interleaving
    assign ini_req[i]  = '{wen:   wen_i[i],
                           be:    be_i[i],
                           row:   addr_i[i][byte_off_w + bank_w +: `TCDM_ROW_W],
                           wdata: wdata_i[i]};
  end

  for (genvar b = 0; b < num_bank; b++) begin : gen_bank
    logic [num_ini-1:0] hit;    // Initiators aiming at this bank
    ini_idx_t           rr_q;   // Highest priority initiator
    ini_idx_t           rr_d;
    ini_idx_t           win;
    logic               found;

    for (genvar i = 0; i < num_ini; i++) begin : gen_hit
      assign hit[i] = req_i[i] && (bank_sel[i] == bank_idx_t'(b));
    end

    // First requester at or after the pointer
    always_comb begin
      int unsigned idx;
      idx   = 0;
      win   = rr_q;
      found = 1'b0;
      for (int unsigned k = 0; k < num_ini; k++) begin
        idx = (32'(rr_q) + k) % num_ini;
        if (!found && hit[idx]) begin
          found = 1'b1;
          win   = ini_idx_t'(idx);
        end
      end
    end

    assign bank_vld_o[b] = found && bank_free_i[b];  // Masked when out of credits
    assign bank_ini_o[b] = win;
    assign bank_req_o[b] = ini_req[win];

    // Pointer moves past the winner on a grant only
    assign rr_d = bank_vld_o[b] ? ini_idx_t'((32'(win) + 1) % num_ini) : rr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_d;
      end
    end
  end

  // Grant return, an initiator wins at most one bank
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < num_bank; b++) begin
      if (bank_vld_o[b]) gnt_o[bank_ini_o[b]] = 1'b1;
    end
  end

endmodule

//--- rtl/tcdm_resp_xbar.sv
// Response crossbar: each initiator picks a target queue head addressed to it, round-robin
`include "tcdm_cfg.svh"

module tcdm_resp_xbar import tcdm_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic     [`TCDM_NUM_BANK-1:0]   q_vld_i,    // Queue not empty
  input  ini_idx_t [`TCDM_NUM_BANK-1:0]   q_ini_i,    // Owner of each head
  input  data_t    [`TCDM_NUM_BANK-1:0]   q_rdata_i,
  output logic     [`TCDM_NUM_BANK-1:0]   q_pop_o,
  output logic     [`TCDM_NUM_INI-1:0]    vld_o,
  input  logic     [`TCDM_NUM_INI-1:0]    rdy_i,
  output data_t    [`TCDM_NUM_INI-1:0]    rdata_o
);

  localparam int unsigned num_ini  = `TCDM_NUM_INI;
  localparam int unsigned num_bank = `TCDM_NUM_BANK;

  bank_idx_t [num_ini-1:0] sel;  // Chosen queue per initiator

  for (genvar i = 0; i < num_ini; i++) begin : gen_ini
    logic [num_bank-1:0] cand;  // Heads owned by this initiator
    bank_idx_t           rr_q;
    bank_idx_t           rr_d;
    bank_idx_t           win;
    logic                found;

    for (genvar b = 0; b < num_bank; b++) begin : gen_cand
      assign cand[b] = q_vld_i[b] && (q_ini_i[b] == ini_idx_t'(i));
    end

    always_comb begin
      int unsigned idx;
      idx   = 0;
      win   = rr_q;
      found = 1'b0;
      for (int unsigned k = 0; k < num_bank; k++) begin
        idx = (32'(rr_q) + k) % num_bank;
        if (!found && cand[idx]) begin
          found = 1'b1;
          win   = bank_idx_t'(idx);
        end
      end
    end

    assign sel[i]     = win;
    assign vld_o[i]   = found;
    assign rdata_o[i] = q_rdata_i[win];

    always_comb begin
      rr_d = rr_q;
      if (found && rdy_i[i]) rr_d = bank_idx_t'((32'(win) + 1) % num_bank);  // Past winner
      else if (found) rr_d = win;  // Stalled, stay on the shown head
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_d;
      end
    end
  end

  // Pop on handshake, each head has a single owner
  always_comb begin
    q_pop_o = '0;
    for (int unsigned i = 0; i < num_ini; i++) begin
      if (vld_o[i] && rdy_i[i]) q_pop_o[sel[i]] = 1'b1;
    end
  end

endmodule

//--- rtl/tcdm_target_queue.sv
// Per-bank response FIFO with the credit counter that throttles requests to that bank
`include "tcdm_cfg.svh"

module tcdm_target_queue import tcdm_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            accept_i,      // Request granted to this bank
  tcdm_resp_if.slv        resp,          // Bank response, pushed as it comes
  input  logic            pop_i,
  output logic            free_o,        // Credits left
  output logic            head_vld_o,
  output ini_idx_t        head_ini_o,
  output data_t           head_rdata_o
);

  localparam int unsigned depth = `TCDM_NUM_OUTSTANDING;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   cnt_q;     // Entries held
  logic [ptr_w:0]   usage_q;   // Credits in use
  logic [ptr_w:0]   usage_d;
  logic             pop;
  logic             pop_q;     // Slot release lags pop by a cycle

  data_t    rdata_mem [depth];
  ini_idx_t ini_mem   [depth];

  assign pop = pop_i && head_vld_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (resp.vld) begin
      rdata_mem[wr_ptr_q] <= resp.rdata;
      ini_mem[wr_ptr_q]   <= resp.ini;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (resp.vld) wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({resp.vld, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Idle or push with pop
      endcase
    end
  end

  assign head_vld_o   = (cnt_q != '0);  // Registered, one cycle after push
  assign head_ini_o   = ini_mem[rd_ptr_q];
  assign head_rdata_o = rdata_mem[rd_ptr_q];

  // Credit counter, every accepted request returns a response
  always_comb begin
    usage_d = usage_q;
    if (accept_i) usage_d = usage_d + 1'b1;
    if (pop_q) usage_d = usage_d - 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usage_q <= '0;
      pop_q   <= 1'b0;
    end else begin
      usage_q <= usage_d;
      pop_q   <= pop;
    end
  end

  assign free_o = (usage_q != (ptr_w + 1)'(depth));

endmodule
